//--- Bender.yml
package:
  name: dual_issue

sources:
  - dual_issue_pkg.sv
  - fetch_queue.sv
  - slot_decoder.sv
  - issue_pairing.sv
  - dual_issue_unit.sv
  - target: simulation
    files:
      - tb_dual_issue.sv

//--- all.f
dual_issue_pkg.sv
fetch_queue.sv
slot_decoder.sv
issue_pairing.sv
dual_issue_unit.sv
tb_dual_issue.sv

//--- dual_issue_pkg.sv
package dual_issue_pkg;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Widths
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef logic [31:0] word_t;
  typedef logic [63:0] fetch_data_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [1:0] issue_count_t;
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  localparam int default_queue_depth = 8;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RV32I encodings
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam opcode_t opcode_lui = 7'b0110111;
  localparam opcode_t opcode_auipc = 7'b0010111;
  localparam opcode_t opcode_jal = 7'b1101111;
  localparam opcode_t opcode_jalr = 7'b1100111;
  localparam opcode_t opcode_branch = 7'b1100011;
  localparam opcode_t opcode_load = 7'b0000011;
  localparam opcode_t opcode_store = 7'b0100011;
  localparam opcode_t opcode_immediate = 7'b0010011;
  localparam opcode_t opcode_register = 7'b0110011;
  localparam opcode_t opcode_fence = 7'b0001111;
  localparam opcode_t opcode_system = 7'b1110011;

  localparam funct3_t funct_add = 3'b000;
  localparam funct3_t funct_sll = 3'b001;
  localparam funct3_t funct_slt = 3'b010;
  localparam funct3_t funct_sltu = 3'b011;
  localparam funct3_t funct_xor = 3'b100;
  localparam funct3_t funct_srl = 3'b101;
  localparam funct3_t funct_or = 3'b110;
  localparam funct3_t funct_and = 3'b111;

  // Plain form, and the alternate form used by sub and sra
  localparam funct7_t funct7_base = 7'b0000000;
  localparam funct7_t funct7_alt = 7'b0100000;

  // addi x0,x0,0
  localparam word_t nop_instr = 32'h0000_0013;

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Shared records
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic valid;
    word_t pc;
    word_t instr;
  } queue_slot_t;

  typedef struct packed {
    logic basic;
    logic complex;
    logic wren;
    logic rden1;
    logic rden2;
    reg_addr_t waddr;
    reg_addr_t raddr1;
    reg_addr_t raddr2;
  } slot_info_t;

  typedef struct packed {
    word_t pc;
    word_t npc;
    word_t instr;
  } issue_lane_t;

endpackage

//--- dual_issue_unit.sv
`timescale 1ns/10ps

module dual_issue_unit #(
  parameter int queue_depth = dual_issue_pkg::default_queue_depth
) (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input dual_issue_pkg::word_t fetch_pc,
  input dual_issue_pkg::fetch_data_t fetch_data,
  input logic clear,
  input logic issue_stall,
  output dual_issue_pkg::issue_lane_t lane0,
  output dual_issue_pkg::issue_lane_t lane1,
  output dual_issue_pkg::issue_count_t issue_count,
  output logic swap,
  output logic fetch_full
);
  import dual_issue_pkg::*;

  queue_slot_t head0;
  queue_slot_t head1;
  slot_info_t info0;
  slot_info_t info1;

  fetch_queue #(
    .queue_depth(queue_depth)
  ) queue (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .clear(clear),
    .issue_count(issue_count),
    .head0(head0),
    .head1(head1),
    .fetch_full(fetch_full)
  );

  slot_decoder decode0 (
    .instr(head0.instr),
    .info(info0)
  );

  slot_decoder decode1 (
    .instr(head1.instr),
    .info(info1)
  );

  issue_pairing pairing (
    .clock(clock),
    .reset(reset),
    .head0(head0),
    .head1(head1),
    .info0(info0),
    .info1(info1),
    .issue_stall(issue_stall),
    .issue_count(issue_count),
    .swap(swap),
    .lane0(lane0),
    .lane1(lane1)
  );

endmodule

//--- fetch_queue.sv
`timescale 1ns/10ps

module fetch_queue #(
  parameter int queue_depth = dual_issue_pkg::default_queue_depth
) (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input dual_issue_pkg::word_t fetch_pc,
  input dual_issue_pkg::fetch_data_t fetch_data,
  input logic clear,
  input dual_issue_pkg::issue_count_t issue_count,
  output dual_issue_pkg::queue_slot_t head0,
  output dual_issue_pkg::queue_slot_t head1,
  output logic fetch_full
);
  import dual_issue_pkg::*;

  localparam int index_width = $clog2(queue_depth);

  typedef logic [index_width-1:0] index_t;
  typedef logic [index_width:0] occupancy_t;

  word_t pc_mem [queue_depth];
  word_t instr_mem [queue_depth];

  index_t wr_index;
  index_t wr_next;
  index_t rd_index;
  index_t rd_next;
  occupancy_t occupancy;
  occupancy_t occupancy_next;
  logic fetch_accept;

  if (queue_depth < 4 || (queue_depth & (queue_depth - 1)) != 0) begin : g_depth_check
    $error("fetch_queue needs a power of two depth of at least 4");
  end

  // A pair is only taken while the queue is at most half full
  assign fetch_accept = fetch_valid && !fetch_full && !clear;
  assign wr_next = wr_index + index_t'(1);
  assign rd_next = rd_index + index_t'(1);

  always_comb begin
    if (clear) begin
      occupancy_next = '0;
    end else begin
      occupancy_next = occupancy - occupancy_t'(issue_count);
      if (fetch_accept) begin
        occupancy_next = occupancy_next + occupancy_t'(2);
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_index <= '0;
      rd_index <= '0;
      occupancy <= '0;
      fetch_full <= 1'b0;
    end else begin
      if (clear) begin
        wr_index <= '0;
        rd_index <= '0;
      end else begin
        rd_index <= rd_index + index_t'(issue_count);
        if (fetch_accept) begin
          wr_index <= wr_index + index_t'(2);
        end
      end
      occupancy <= occupancy_next;
      fetch_full <= occupancy_next > occupancy_t'(queue_depth / 2);
    end
  end

  // Low word sits at the fetch pc, high word one word later
  always_ff @(posedge clock) begin
    if (fetch_accept) begin
      pc_mem[wr_index] <= fetch_pc;
      instr_mem[wr_index] <= fetch_data[31:0];
      pc_mem[wr_next] <= fetch_pc + 32'd4;
      instr_mem[wr_next] <= fetch_data[63:32];
    end
  end

  always_comb begin
    head0.valid = occupancy > occupancy_t'(0);
    head0.pc = head0.valid ? pc_mem[rd_index] : '0;
    head0.instr = head0.valid ? instr_mem[rd_index] : nop_instr;
    head1.valid = occupancy > occupancy_t'(1);
    head1.pc = head1.valid ? pc_mem[rd_next] : '0;
    head1.instr = head1.valid ? instr_mem[rd_next] : nop_instr;
  end

  // The pairing logic must never retire entries that are not held
  assert property (@(posedge clock) disable iff (!reset)
    occupancy_t'(issue_count) <= occupancy);

  assert property (@(posedge clock) disable iff (!reset)
    occupancy <= occupancy_t'(queue_depth));

endmodule

//--- issue_pairing.sv
`timescale 1ns/10ps

module issue_pairing (
  input logic clock,
  input logic reset,
  input dual_issue_pkg::queue_slot_t head0,
  input dual_issue_pkg::queue_slot_t head1,
  input dual_issue_pkg::slot_info_t info0,
  input dual_issue_pkg::slot_info_t info1,
  input logic issue_stall,
  output dual_issue_pkg::issue_count_t issue_count,
  output logic swap,
  output dual_issue_pkg::issue_lane_t lane0,
  output dual_issue_pkg::issue_lane_t lane1
);
  import dual_issue_pkg::*;

  logic known0;
  logic known1;
  logic raw_hazard;
  issue_count_t pair_count;
  queue_slot_t first;
  queue_slot_t second;

  // Compressed encodings advance by a half word
  function automatic word_t next_pc(input queue_slot_t slot);
    return slot.pc + ((slot.instr[1:0] == 2'b11) ? 32'd4 : 32'd2);
  endfunction

  assign known0 = info0.basic || info0.complex;
  assign known1 = info1.basic || info1.complex;

  assign raw_hazard = info0.wren &&
                      ((info1.rden1 && info1.raddr1 == info0.waddr) ||
                       (info1.rden2 && info1.raddr2 == info0.waddr));

  always_comb begin
    if (!known0 || !known1 || (info0.complex && info1.complex) || raw_hazard) begin
      pair_count = 2'd1;
    end else begin
      pair_count = 2'd2;
    end
    if (issue_stall) begin
      pair_count = 2'd0;
    end
    // Never issue more than the queue holds
    if (!head0.valid) begin
      issue_count = 2'd0;
    end else if (!head1.valid && pair_count == 2'd2) begin
      issue_count = 2'd1;
    end else begin
      issue_count = pair_count;
    end
  end

  // A complex instruction must sit in lane 0
  assign swap = issue_count == 2'd2 && info0.basic && info1.complex;

  assign first = swap ? head1 : head0;
  assign second = swap ? head0 : head1;

  always_comb begin
    lane0.pc = (issue_count > 2'd0) ? first.pc : '1;
    lane0.npc = (issue_count > 2'd0) ? next_pc(first) : '1;
    lane0.instr = (issue_count > 2'd0) ? first.instr : nop_instr;
    lane1.pc = (issue_count > 2'd1) ? second.pc : '1;
    lane1.npc = (issue_count > 2'd1) ? next_pc(second) : '1;
    lane1.instr = (issue_count > 2'd1) ? second.instr : nop_instr;
  end

  assert property (@(posedge clock) disable iff (!reset)
    swap |-> issue_count == 2'd2 && lane0.pc == head1.pc && lane1.pc == head0.pc);

endmodule

//--- slot_decoder.sv
`timescale 1ns/10ps

module slot_decoder (
  input dual_issue_pkg::word_t instr,
  output dual_issue_pkg::slot_info_t info
);
  import dual_issue_pkg::*;

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;

  logic imm_legal;
  logic reg_legal;
  logic basic;
  logic complex;
  logic writes_rd;
  logic rden1;
  logic rden2;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Legal ALU forms
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Immediate shifts carry the shift type in the upper bits
  always_comb begin
    case (funct3)
      funct_add, funct_slt, funct_sltu, funct_xor, funct_or, funct_and: begin
        imm_legal = 1'b1;
      end
      funct_sll: begin
        imm_legal = funct7 == funct7_base;
      end
      funct_srl: begin
        imm_legal = funct7 == funct7_base || funct7 == funct7_alt;
      end
      default: begin
        imm_legal = 1'b0;
      end
    endcase
  end

  // Only sub and sra use the alternate funct7
  always_comb begin
    case (funct7)
      funct7_base: begin
        reg_legal = 1'b1;
      end
      funct7_alt: begin
        reg_legal = funct3 == funct_add || funct3 == funct_srl;
      end
      default: begin
        reg_legal = 1'b0;
      end
    endcase
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Classification and register use
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    basic = 1'b0;
    complex = 1'b0;
    writes_rd = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    case (opcode)
      opcode_lui, opcode_auipc: begin
        basic = 1'b1;
        writes_rd = 1'b1;
      end
      opcode_jal: begin
        complex = 1'b1;
        writes_rd = 1'b1;
      end
      opcode_jalr, opcode_load: begin
        complex = 1'b1;
        writes_rd = 1'b1;
        rden1 = 1'b1;
      end
      opcode_branch, opcode_store: begin
        complex = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
      end
      opcode_immediate: begin
        basic = imm_legal;
        complex = !imm_legal;
        writes_rd = 1'b1;
        rden1 = 1'b1;
      end
      opcode_register: begin
        basic = reg_legal;
        complex = !reg_legal;
        writes_rd = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
      end
      opcode_fence, opcode_system: begin
        complex = 1'b1;
      end
      default: begin
        // Anything else is unknown and issues alone
      end
    endcase
  end

  // Writes to x0 are dropped so they never create a dependence
  always_comb begin
    info.basic = basic;
    info.complex = complex;
    info.wren = writes_rd && rd != '0;
    info.rden1 = rden1;
    info.rden2 = rden2;
    info.waddr = rd;
    info.raddr1 = rs1;
    info.raddr2 = rs2;
  end

endmodule

//--- tb_dual_issue.sv
`timescale 1ns/10ps

module tb_dual_issue;
  import dual_issue_pkg::*;

  localparam int depth = 8;
  localparam int idle_limit = 40;
  localparam logic [1:0] kind_basic = 2'd0;
  localparam logic [1:0] kind_complex = 2'd1;
  localparam logic [1:0] kind_unknown = 2'd2;

  // One generated instruction with the register use that the issue rules look at
  typedef struct packed {
    word_t pc;
    word_t instr;
    logic [1:0] kind;
    logic wr;
    reg_addr_t rd;
    logic use1;
    reg_addr_t rs1;
    logic use2;
    reg_addr_t rs2;
  } entry_t;

  logic clock;
  logic reset;
  logic fetch_valid;
  word_t fetch_pc;
  fetch_data_t fetch_data;
  logic clear;
  logic issue_stall;
  issue_lane_t lane0;
  issue_lane_t lane1;
  issue_count_t issue_count;
  logic swap;
  logic fetch_full;

  entry_t offer0;
  entry_t offer1;
  entry_t model_q[$];
  logic model_full;
  int model_count;
  int error_count;
  int check_count;
  logic [31:0] lfsr_state;
  word_t fetch_next_pc;

  dual_issue_unit #(
    .queue_depth(depth)
  ) uut (
    .clock(clock),
    .reset(reset),
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .fetch_data(fetch_data),
    .clear(clear),
    .issue_stall(issue_stall),
    .lane0(lane0),
    .lane1(lane1),
    .issue_count(issue_count),
    .swap(swap),
    .fetch_full(fetch_full)
  );

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus helpers
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int count, output logic [31:0] value);
    value = '0;
    repeat (count) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  // Encodings written out by field, rd/rs1/rs2 in their RV32I positions
  function automatic entry_t make_entry(input word_t pc, input int sel, input reg_addr_t rd,
                                        input reg_addr_t rs1, input reg_addr_t rs2);
    entry_t e;
    e = '0;
    e.pc = pc;
    e.rd = rd;
    e.rs1 = rs1;
    e.rs2 = rs2;
    case (sel)
      0: begin
        e.instr = {12'd5, rs1, 3'b000, rd, 7'b0010011};
        {e.kind, e.wr, e.use1, e.use2} = {kind_basic, 3'b110};
      end
      1: begin
        e.instr = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
        {e.kind, e.wr, e.use1, e.use2} = {kind_basic, 3'b111};
      end
      2: begin
        e.instr = {20'h12345, rd, 7'b0110111};
        {e.kind, e.wr, e.use1, e.use2} = {kind_basic, 3'b100};
      end
      3: begin
        e.instr = {12'd0, rs1, 3'b010, rd, 7'b0000011};
        {e.kind, e.wr, e.use1, e.use2} = {kind_complex, 3'b110};
      end
      4: begin
        e.instr = {7'b0000000, rs2, rs1, 3'b000, 5'd0, 7'b1100011};
        {e.kind, e.wr, e.use1, e.use2} = {kind_complex, 3'b011};
      end
      6: begin
        e.instr = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
        {e.kind, e.wr, e.use1, e.use2} = {kind_basic, 3'b111};
      end
      7: begin
        // mul is outside RV32I, so the register form is illegal
        e.instr = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
        {e.kind, e.wr, e.use1, e.use2} = {kind_complex, 3'b111};
      end
      default: begin
        // fadd.s
        e.instr = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b1010011};
        e.kind = kind_unknown;
      end
    endcase
    return e;
  endfunction

  task automatic random_entry(input word_t pc, output entry_t e);
    logic [31:0] sel;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    random_bits(3, sel);
    random_bits(2, rd);
    random_bits(2, rs1);
    random_bits(2, rs2);
    e = make_entry(pc, int'(sel), reg_addr_t'(rd), reg_addr_t'(rs1), reg_addr_t'(rs2));
  endtask

  task automatic drive_pair(input entry_t a, input entry_t b);
    fetch_valid <= 1'b1;
    fetch_pc <= a.pc;
    fetch_data <= {b.instr, a.instr};
    offer0 <= a;
    offer1 <= b;
  endtask

  task automatic offer_pair(input entry_t a, input entry_t b);
    @(posedge clock);
    drive_pair(a, b);
    @(posedge clock);
    fetch_valid <= 1'b0;
  endtask

  // Issue is done once the DUT reports nothing left to issue
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    @(negedge clock);
    while (issue_count !== 2'd0 && cycles < idle_limit) begin
      @(negedge clock);
      cycles++;
    end
    if (issue_count !== 2'd0) begin
      $display("Timeout: the instruction queue did not drain");
      $display("=== FAIL ===");
      $finish;
    end
  endtask

  task automatic run_directed_pair(input int sel_a, input reg_addr_t rd_a, input reg_addr_t rs_a,
                                   input int sel_b, input reg_addr_t rd_b, input reg_addr_t rs_b);
    entry_t a;
    entry_t b;
    a = make_entry(fetch_next_pc, sel_a, rd_a, rs_a, rs_a);
    b = make_entry(fetch_next_pc + 32'd4, sel_b, rd_b, rs_b, 5'd9);
    fetch_next_pc += 32'd8;
    offer_pair(a, b);
    wait_idle();
  endtask

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and checks
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic int expected_count(input entry_t e0, input entry_t e1, input int held,
                                        input logic stall);
    if (stall || held == 0) return 0;
    if (held == 1) return 1;
    if (e0.kind == kind_unknown || e1.kind == kind_unknown) return 1;
    if (e0.kind == kind_complex && e1.kind == kind_complex) return 1;
    if (e0.wr && e0.rd != 5'd0 &&
        ((e1.use1 && e1.rs1 == e0.rd) || (e1.use2 && e1.rs2 == e0.rd))) return 1;
    return 2;
  endfunction

  task automatic compare_word(input string name, input word_t got, input word_t want);
    check_count++;
    assert (got === want) else begin
      error_count++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, want);
    end
  endtask

  always @(negedge clock) begin : check_outputs
    entry_t e0;
    entry_t e1;
    entry_t first;
    entry_t second;
    logic exp_swap;
    if (!reset) begin
      model_count = 0;
    end else begin
      e0 = (model_q.size() > 0) ? model_q[0] : '0;
      e1 = (model_q.size() > 1) ? model_q[1] : '0;
      model_count = expected_count(e0, e1, model_q.size(), issue_stall);
      exp_swap = model_count == 2 && e0.kind == kind_basic && e1.kind == kind_complex;
      first = exp_swap ? e1 : e0;
      second = exp_swap ? e0 : e1;
      compare_word("issue_count", word_t'(issue_count), word_t'(model_count));
      compare_word("swap", word_t'(swap), word_t'(exp_swap));
      compare_word("fetch_full", word_t'(fetch_full), word_t'(model_full));
      compare_word("lane0.pc", lane0.pc, (model_count > 0) ? first.pc : '1);
      compare_word("lane0.npc", lane0.npc, (model_count > 0) ? first.pc + 32'd4 : '1);
      compare_word("lane0.instr", lane0.instr, (model_count > 0) ? first.instr : 32'h13);
      compare_word("lane1.pc", lane1.pc, (model_count > 1) ? second.pc : '1);
      compare_word("lane1.npc", lane1.npc, (model_count > 1) ? second.pc + 32'd4 : '1);
      compare_word("lane1.instr", lane1.instr, (model_count > 1) ? second.instr : 32'h13);
    end
  end

  // Scoreboard of accepted pcs, in fetch order
  always @(posedge clock) begin
    if (!reset || clear) begin
      model_q.delete();
      model_full = 1'b0;
    end else begin
      repeat (model_count) begin
        if (model_q.size() > 0) void'(model_q.pop_front());
      end
      if (fetch_valid && !model_full) begin
        model_q.push_back(offer0);
        model_q.push_back(offer1);
      end
      model_full = model_q.size() > depth / 2;
    end
  end

  assert property (@(posedge clock) disable iff (!reset) clear |=> issue_count == 2'd0)
    else begin
      error_count++;
      $display("Instructions issued in the cycle after a clear");
    end

  assert property (@(posedge clock) disable iff (!reset) issue_stall |-> issue_count == 2'd0)
    else begin
      error_count++;
      $display("Instructions issued while issue_stall was high");
    end

  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin : stimulus
    entry_t a;
    entry_t b;
    logic [31:0] roll;
    lfsr_state = 32'h3bb3_014a;
    fetch_next_pc = 32'h0000_1000;
    error_count = 0;
    check_count = 0;
    model_full = 1'b0;
    model_count = 0;
    offer0 = '0;
    offer1 = '0;
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_data = '0;
    clear = 1'b0;
    issue_stall = 1'b0;
    repeat (4) @(posedge clock);
    reset <= 1'b1;
    repeat (3) @(posedge clock);

    // Independent, dependent, two complex, unknown first, basic then complex
    run_directed_pair(0, 5'd1, 5'd0, 0, 5'd2, 5'd0);
    run_directed_pair(0, 5'd3, 5'd1, 1, 5'd4, 5'd3);
    run_directed_pair(3, 5'd5, 5'd1, 4, 5'd0, 5'd2);
    run_directed_pair(5, 5'd6, 5'd1, 0, 5'd7, 5'd2);
    run_directed_pair(0, 5'd6, 5'd1, 3, 5'd7, 5'd2);

    // Stalled issue fills the queue, and later pairs are dropped
    @(posedge clock);
    issue_stall <= 1'b1;
    repeat (5) begin
      random_entry(fetch_next_pc, a);
      random_entry(fetch_next_pc + 32'd4, b);
      fetch_next_pc += 32'd8;
      offer_pair(a, b);
    end
    @(posedge clock);
    issue_stall <= 1'b0;
    wait_idle();

    // Clear a stalled queue, then resume
    @(posedge clock);
    issue_stall <= 1'b1;
    run_directed_pair(1, 5'd1, 5'd2, 1, 5'd3, 5'd2);
    @(posedge clock);
    clear <= 1'b1;
    @(posedge clock);
    clear <= 1'b0;
    issue_stall <= 1'b0;
    run_directed_pair(2, 5'd1, 5'd0, 6, 5'd2, 5'd3);

    // Random traffic where the producer holds a pair until it is taken
    for (int i = 0; i < 240; i++) begin
      @(posedge clock);
      random_bits(2, roll);
      issue_stall <= roll == 0;
      if (!(fetch_valid && fetch_full)) begin
        random_bits(2, roll);
        if (roll != 0) begin
          random_entry(fetch_next_pc, a);
          random_entry(fetch_next_pc + 32'd4, b);
          fetch_next_pc += 32'd8;
          drive_pair(a, b);
        end else begin
          fetch_valid <= 1'b0;
        end
      end
    end
    @(posedge clock);
    fetch_valid <= 1'b0;
    issue_stall <= 1'b0;
    wait_idle();

    $display("checks %0d errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
